//--- hw/dcache_pkg.sv
package dcache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////

    // word address, not byte address
    localparam int addr_w     = 16;
    localparam int tag_w      = 10;
    localparam int index_w    = 4;
    localparam int offset_w   = 2;
    localparam int word_w     = 32;
    localparam int line_words = 4;
    // lru is a single bit per set, so two ways only
    localparam int num_ways   = 2;

    //////////////////////////////
    // address and request types
    //////////////////////////////

    // one word address seen as tag / set / word-in-line
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } cache_addr_t;

    // processor commands
    typedef enum logic [1:0] {
        cmd_read  = 2'd0,
        cmd_write = 2'd1,
        cmd_inval = 2'd2
    } cpu_cmd_e;

    // processor request, held while cpu_req is high
    typedef struct packed {
        cpu_cmd_e          cmd;
        cache_addr_t       addr;
        logic [word_w-1:0] wdata;
    } cpu_req_t;

    // memory request, line base address for reads
    typedef struct packed {
        logic              we;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] wdata;
    } mem_req_t;

    // word 0 sits in the low bits
    typedef logic [line_words-1:0][word_w-1:0] line_t;

    // one bit per way
    typedef logic [num_ways-1:0] way_vec_t;

endpackage

//--- hw/dual_port_ram.sv
`timescale 1ns/10ps

module dual_port_ram #(
    parameter int data_w = 32,
    parameter int addr_w = 4
) (
    input  logic              clk,
    // write port
    input  logic              we,
    input  logic [addr_w-1:0] waddr,
    input  logic [data_w-1:0] din,
    // read port
    input  logic [addr_w-1:0] raddr,
    output logic [data_w-1:0] dout
);

    // storage, maps onto block or distributed ram
    logic [data_w-1:0] mem [2**addr_w];

    // write side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // registered read
    // same-address read during a write sees the old word
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

//--- hw/dcache_tag_valid.sv
`timescale 1ns/10ps

module dcache_tag_valid (
    input  logic                           clk,
    input  logic                           reset,
    // set being looked up or written
    input  logic [dcache_pkg::index_w-1:0] index,
    // tag to compare, also the tag written on refill
    input  logic [dcache_pkg::tag_w-1:0]   cmp_tag,
    input  dcache_pkg::way_vec_t           tag_we,
    input  dcache_pkg::way_vec_t           valid_clr,
    output dcache_pkg::way_vec_t           hit,
    output dcache_pkg::way_vec_t           valid
);
    import dcache_pkg::*;

    // index lined up with the ram read data
    logic [index_w-1:0] index_q;

    always_ff @(posedge clk) begin
        index_q <= index;
    end

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        // stored tag of this way for index_q
        logic [tag_w-1:0]        tag_rd;
        // one valid bit per set
        logic [(1<<index_w)-1:0] valid_bits;

        dual_port_ram #(
            .data_w (tag_w),
            .addr_w (index_w)
        ) i_tag_ram (
            .clk   (clk),
            .we    (tag_we[w]),
            .waddr (index),
            .din   (cmp_tag),
            .raddr (index),
            .dout  (tag_rd)
        );

        // only this way's bits move here
        // clear wins if both ever fire
        always_ff @(posedge clk) begin
            if (reset) begin
                valid_bits <= '0;
            end else if (valid_clr[w]) begin
                valid_bits[index] <= 1'b0;
            end else if (tag_we[w]) begin
                valid_bits[index] <= 1'b1;
            end
        end

        // valid read at the same set as the tag ram output
        assign valid[w] = valid_bits[index_q];
        // compare against the lookup tag
        assign hit[w]   = valid[w] && (tag_rd == cmp_tag);
    end

endmodule

//--- hw/dcache_data_array.sv
`timescale 1ns/10ps

module dcache_data_array (
    input  logic                                      clk,
    input  logic [dcache_pkg::index_w-1:0]            index,
    // word chosen for a single-word write
    input  logic [dcache_pkg::offset_w-1:0]           word_sel,
    // full-line write, one bit per way
    input  dcache_pkg::way_vec_t                      refill_we,
    // single-word write, one bit per way
    input  dcache_pkg::way_vec_t                      word_we,
    input  dcache_pkg::line_t                         refill_line,
    input  logic [dcache_pkg::word_w-1:0]             wdata,
    output dcache_pkg::line_t [dcache_pkg::num_ways-1:0] rd_line
);
    import dcache_pkg::*;

    // one narrow ram per word so a write hit touches one word only
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        for (genvar i = 0; i < line_words; i++) begin : g_word
            logic              word_wen;
            logic [word_w-1:0] word_din;

            // refill writes every word of the way
            assign word_wen = refill_we[w] ||
                              (word_we[w] && (word_sel == offset_w'(i)));
            // refill data has priority over the cpu word
            assign word_din = refill_we[w] ? refill_line[i] : wdata;

            dual_port_ram #(
                .data_w (word_w),
                .addr_w (index_w)
            ) i_word_ram (
                .clk   (clk),
                .we    (word_wen),
                .waddr (index),
                .din   (word_din),
                .raddr (index),
                .dout  (rd_line[w][i])
            );
        end
    end

endmodule

//--- hw/dcache_replace.sv
`timescale 1ns/10ps

module dcache_replace (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [dcache_pkg::index_w-1:0] index,
    // valid bits of the set from the tag array
    input  dcache_pkg::way_vec_t           valid,
    // way used by a hit or a refill
    input  logic                           touch,
    input  dcache_pkg::way_vec_t           touch_way,
    // one-hot way to refill
    output dcache_pkg::way_vec_t           victim_way
);
    import dcache_pkg::*;

    // set means way 1 is least recently used
    logic [(1<<index_w)-1:0] lru;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (touch) begin
            // touching way 0 leaves way 1 as lru, and the other way round
            lru[index] <= (touch_way == way_vec_t'(1));
        end
    end

    always_comb begin
        // default from the lru bit
        victim_way = lru[index] ? way_vec_t'(2) : way_vec_t'(1);
        // an empty way beats the lru choice, lowest first
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                victim_way = way_vec_t'(1) << w;
            end
        end
    end

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                                      clk,
    input  logic                                      reset,
    // processor side, four-phase
    input  logic                                      cpu_req,
    input  dcache_pkg::cpu_req_t                      cpu_cmd,
    output logic                                      cpu_ack,
    output logic [dcache_pkg::word_w-1:0]             cpu_rdata,
    // memory side, four-phase
    output logic                                      mem_req,
    output dcache_pkg::mem_req_t                      mem_cmd,
    input  logic                                      mem_ack,
    input  dcache_pkg::line_t                         mem_rdata,
    // datapath control
    output logic [dcache_pkg::index_w-1:0]            lookup_index,
    output logic [dcache_pkg::tag_w-1:0]              lookup_tag,
    output dcache_pkg::way_vec_t                      tag_we,
    output dcache_pkg::way_vec_t                      valid_clr,
    output dcache_pkg::way_vec_t                      data_we,
    output dcache_pkg::way_vec_t                      word_we,
    output logic [dcache_pkg::offset_w-1:0]           word_sel,
    output logic [dcache_pkg::word_w-1:0]             word_wdata,
    output dcache_pkg::line_t                         refill_line,
    input  dcache_pkg::way_vec_t                      hit,
    input  dcache_pkg::line_t [dcache_pkg::num_ways-1:0] rd_line,
    output logic                                      touch,
    output dcache_pkg::way_vec_t                      touch_way,
    input  dcache_pkg::way_vec_t                      victim_way
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_compare,
        st_mem_wait,
        st_mem_release,
        st_fill,
        st_respond,
        st_release
    } state_e;

    state_e            state_q;
    // latched request, stable for the whole transaction
    cpu_req_t          req_q;
    // line returned by memory
    line_t             line_q;
    // way picked at compare time
    way_vec_t          victim_q;
    // addressed word out of the hit way
    logic [word_w-1:0] hit_word;

    //////////////////////////////
    // datapath drive
    //////////////////////////////

    assign lookup_index = req_q.addr.index;
    assign lookup_tag   = req_q.addr.tag;
    assign word_sel     = req_q.addr.offset;
    assign word_wdata   = req_q.wdata;
    assign refill_line  = line_q;

    // refill writes tag, valid and data of the victim in one cycle
    assign tag_we  = (state_q == st_fill) ? victim_q : '0;
    assign data_we = (state_q == st_fill) ? victim_q : '0;

    // invalidate hit clears only the matching way
    assign valid_clr = (state_q == st_compare && req_q.cmd == cmd_inval) ? hit : '0;
    // write hit updates the cached word
    assign word_we   = (state_q == st_compare && req_q.cmd == cmd_write) ? hit : '0;

    // lru update on read/write hit and on refill
    assign touch = (state_q == st_compare && req_q.cmd != cmd_inval && |hit) ||
                   (state_q == st_fill);
    assign touch_way = (state_q == st_fill) ? victim_q : hit;

    // hit vector is one-hot, or-reduce the ways
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                hit_word = hit_word | rd_line[w][req_q.addr.offset];
            end
        end
    end

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (cpu_req) begin
                        state_q <= st_lookup;
                    end
                end
                // ram read of the latched set
                st_lookup: begin
                    state_q <= st_compare;
                end
                st_compare: begin
                    case (req_q.cmd)
                        cmd_read: begin
                            if (|hit) begin
                                cpu_ack <= 1'b1;
                                state_q <= st_release;
                            end else begin
                                mem_req <= 1'b1;
                                state_q <= st_mem_wait;
                            end
                        end
                        // write-through, hit or miss
                        cmd_write: begin
                            mem_req <= 1'b1;
                            state_q <= st_mem_wait;
                        end
                        // invalidate never goes to memory
                        default: begin
                            cpu_ack <= 1'b1;
                            state_q <= st_release;
                        end
                    endcase
                end
                st_mem_wait: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state_q <= st_mem_release;
                    end
                end
                // wait for memory to drop ack
                st_mem_release: begin
                    if (!mem_ack) begin
                        state_q <= (req_q.cmd == cmd_read) ? st_fill : st_respond;
                    end
                end
                st_fill: begin
                    state_q <= st_respond;
                end
                st_respond: begin
                    cpu_ack <= 1'b1;
                    state_q <= st_release;
                end
                // hold ack until the cpu lets go
                st_release: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // payload registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        case (state_q)
            st_idle: begin
                if (cpu_req) begin
                    req_q <= cpu_cmd;
                end
            end
            st_compare: begin
                victim_q  <= victim_way;
                cpu_rdata <= hit_word;
                if (req_q.cmd == cmd_write) begin
                    mem_cmd <= '{we: 1'b1, addr: req_q.addr, wdata: req_q.wdata};
                end else begin
                    // line base, offset forced to zero
                    mem_cmd <= '{we: 1'b0,
                                 addr: {req_q.addr.tag, req_q.addr.index, {offset_w{1'b0}}},
                                 wdata: req_q.wdata};
                end
            end
            st_mem_wait: begin
                if (mem_ack) begin
                    line_q <= mem_rdata;
                end
            end
            // word for the cpu straight from the refilled line
            st_fill: begin
                cpu_rdata <= line_q[req_q.addr.offset];
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/10ps

module dcache_top (
    input  logic                          clk,
    input  logic                          reset,
    // processor port
    input  logic                          cpu_req,
    input  dcache_pkg::cpu_req_t          cpu_cmd,
    output logic                          cpu_ack,
    output logic [dcache_pkg::word_w-1:0] cpu_rdata,
    // backing memory port
    output logic                          mem_req,
    output dcache_pkg::mem_req_t          mem_cmd,
    input  logic                          mem_ack,
    input  dcache_pkg::line_t             mem_rdata
);
    import dcache_pkg::*;

    // controller to arrays
    logic [index_w-1:0]       lookup_index;
    logic [tag_w-1:0]         lookup_tag;
    way_vec_t                 tag_we;
    way_vec_t                 valid_clr;
    way_vec_t                 data_we;
    way_vec_t                 word_we;
    logic [offset_w-1:0]      word_sel;
    logic [word_w-1:0]        word_wdata;
    line_t                    refill_line;
    logic                     touch;
    way_vec_t                 touch_way;
    // arrays to controller
    way_vec_t                 hit;
    way_vec_t                 valid;
    line_t [num_ways-1:0]     rd_line;
    way_vec_t                 victim_way;

    dcache_ctrl i_dcache_ctrl (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_cmd      (cpu_cmd),
        .cpu_ack      (cpu_ack),
        .cpu_rdata    (cpu_rdata),
        .mem_req      (mem_req),
        .mem_cmd      (mem_cmd),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .tag_we       (tag_we),
        .valid_clr    (valid_clr),
        .data_we      (data_we),
        .word_we      (word_we),
        .word_sel     (word_sel),
        .word_wdata   (word_wdata),
        .refill_line  (refill_line),
        .hit          (hit),
        .rd_line      (rd_line),
        .touch        (touch),
        .touch_way    (touch_way),
        .victim_way   (victim_way)
    );

    // tag rams and valid bits
    dcache_tag_valid i_dcache_tag_valid (
        .clk       (clk),
        .reset     (reset),
        .index     (lookup_index),
        .cmp_tag   (lookup_tag),
        .tag_we    (tag_we),
        .valid_clr (valid_clr),
        .hit       (hit),
        .valid     (valid)
    );

    // line storage
    dcache_data_array i_dcache_data_array (
        .clk         (clk),
        .index       (lookup_index),
        .word_sel    (word_sel),
        .refill_we   (data_we),
        .word_we     (word_we),
        .refill_line (refill_line),
        .wdata       (word_wdata),
        .rd_line     (rd_line)
    );

    // lru and victim choice
    dcache_replace i_dcache_replace (
        .clk        (clk),
        .reset      (reset),
        .index      (lookup_index),
        .valid      (valid),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

endmodule

//--- test/mem_model.sv
`timescale 1ns/10ps

module mem_model #(
    // negedges from request to ack
    parameter int latency = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_req,
    input  dcache_pkg::mem_req_t mem_cmd,
    output logic                 mem_ack,
    output dcache_pkg::line_t    mem_rdata,
    // refills served since reset
    output int                   line_reads
);
    import dcache_pkg::*;

    // whole word-address space
    logic [word_w-1:0] mem [2**addr_w];
    int                wait_cnt;

    // fill pattern covers every address bit
    initial begin
        for (int a = 0; a < 2**addr_w; a++) begin
            mem[a] = {16'(a) ^ 16'hc35a, 16'(a)};
        end
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        line_reads = 0;
        wait_cnt   = 0;
    end

    // responder runs on the falling edge, cache samples on the rising one
    always @(negedge clk) begin
        if (reset) begin
            mem_ack    = 1'b0;
            line_reads = 0;
            wait_cnt   = 0;
        end else if (mem_req && !mem_ack) begin
            if (wait_cnt < latency - 1) begin
                wait_cnt++;
            end else begin
                wait_cnt = 0;
                if (mem_cmd.we) begin
                    mem[mem_cmd.addr] = mem_cmd.wdata;
                end else begin
                    // line read from the base address upward
                    for (int i = 0; i < line_words; i++) begin
                        mem_rdata[i] = mem[mem_cmd.addr + addr_w'(i)];
                    end
                    line_reads++;
                end
                mem_ack = 1'b1;
            end
        end else if (!mem_req && mem_ack) begin
            // four-phase return to zero
            mem_ack = 1'b0;
        end
    end

endmodule

//--- test/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb;
    import dcache_pkg::*;

    //////////////////////////////
    // run limits
    //////////////////////////////

    localparam int reset_cycles   = 8;
    localparam int num_directed   = 20;
    localparam int num_random     = 200;
    // generous cycle budget per table row
    localparam int timeout_cycles = (num_directed + num_random) * 40 + reset_cycles;

    // one row of the operation table
    typedef struct packed {
        cpu_cmd_e          cmd;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] wdata;
        // expected read word and memory word after the op
        logic [word_w-1:0] exp_word;
        // line reads so far or -1 to skip
        int                exp_reads;
        // ack edges after the request is seen or 0 to skip
        int                exp_edges;
    } op_t;

    logic              clk = 1'b0;
    logic              reset;
    logic              cpu_req;
    cpu_req_t          cpu_cmd;
    logic              cpu_ack;
    logic [word_w-1:0] cpu_rdata;
    logic              mem_req;
    mem_req_t          mem_cmd;
    logic              mem_ack;
    line_t             mem_rdata;
    int                line_reads;

    op_t               ops[$];
    // expected memory contents
    logic [word_w-1:0] shadow [2**addr_w];
    logic [31:0]       rng;
    int                cycle_count = 0;

    // 8 ns period
    always #4 clk = ~clk;

    dcache_top i_dcache_top (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_cmd   (cpu_cmd),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    mem_model #(
        .latency (3)
    ) i_mem_model (
        .clk        (clk),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .line_reads (line_reads)
    );

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: the cache gave no answer within %0d cycles", timeout_cycles);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // power-up memory word for an address
    function automatic logic [word_w-1:0] fill_word(input logic [addr_w-1:0] a);
        return {a ^ 16'hc35a, a};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // append a row with its expected word from the shadow memory
    task automatic add_op(input cpu_cmd_e cmd, input logic [addr_w-1:0] addr,
                          input logic [word_w-1:0] wdata, input int exp_reads,
                          input int exp_edges);
        op_t op;
        if (cmd == cmd_write) begin
            shadow[addr] = wdata;
        end
        op.cmd       = cmd;
        op.addr      = addr;
        op.wdata     = wdata;
        op.exp_word  = shadow[addr];
        op.exp_reads = exp_reads;
        op.exp_edges = exp_edges;
        ops.push_back(op);
    endtask

    task automatic build_table();
        logic [addr_w-1:0] a;
        for (int i = 0; i < 2**addr_w; i++) begin
            shadow[i] = fill_word(addr_w'(i));
        end
        // cold miss then hits in the same line
        add_op(cmd_read,  16'h0041, '0, 1, 0);
        add_op(cmd_read,  16'h0043, '0, 1, 2);
        add_op(cmd_read,  16'h0040, '0, 1, 2);
        // write-through on a hit then on a miss with no allocation
        add_op(cmd_write, 16'h0042, 32'hdeadbeef, 1, 0);
        add_op(cmd_read,  16'h0042, '0, 1, 2);
        add_op(cmd_write, 16'h0105, 32'h0badcafe, 1, 0);
        add_op(cmd_read,  16'h0105, '0, 2, 0);
        // tags 1, 2, 3 all on set 5
        add_op(cmd_read,  16'h0054, '0, 3, 0);
        add_op(cmd_read,  16'h0094, '0, 4, 0);
        add_op(cmd_read,  16'h0055, '0, 4, 2);
        // B is lru here and goes
        add_op(cmd_read,  16'h00d4, '0, 5, 0);
        add_op(cmd_read,  16'h0056, '0, 5, 2);
        add_op(cmd_read,  16'h0097, '0, 6, 0);
        // invalidate hit then refetch
        add_op(cmd_inval, 16'h0054, '0, 6, 2);
        add_op(cmd_read,  16'h0054, '0, 7, 0);
        // invalidate of a line not held
        add_op(cmd_inval, 16'h0200, '0, 7, 2);
        add_op(cmd_read,  16'h0041, '0, 7, 2);
        // written word survives an invalidate in memory
        add_op(cmd_write, 16'h0043, 32'h12345678, 7, 0);
        add_op(cmd_inval, 16'h0040, '0, 7, 2);
        add_op(cmd_read,  16'h0043, '0, 8, 0);
        // random mix over 256 words with 4 tags per set
        rng = 32'd75;
        for (int i = 0; i < num_random; i++) begin
            rng = lcg_next(rng);
            a   = {8'h00, rng[23:16]};
            if (rng[28]) begin
                rng = lcg_next(rng);
                add_op(cmd_write, a, rng, -1, 0);
            end else begin
                add_op(cmd_read, a, '0, -1, 0);
            end
        end
    endtask

    // one full four-phase transaction
    task automatic apply_op(input op_t op, input int n);
        int cycles;
        cpu_cmd = {op.cmd, op.addr, op.wdata};
        cpu_req = 1'b1;
        @(negedge clk);
        cycles = 1;
        while (!cpu_ack) begin
            @(negedge clk);
            cycles++;
        end
        if (op.cmd == cmd_read) begin
            check($sformatf("op %0d read data", n), cpu_rdata, op.exp_word);
        end
        if (op.exp_edges != 0) begin
            check($sformatf("op %0d ack latency", n), cycles - 1, op.exp_edges);
        end
        cpu_req = 1'b0;
        while (cpu_ack) begin
            @(negedge clk);
        end
        if (op.exp_reads >= 0) begin
            check($sformatf("op %0d line reads", n), line_reads, op.exp_reads);
        end
        check($sformatf("op %0d memory word", n), i_mem_model.mem[op.addr], op.exp_word);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        reset   = 1'b1;
        cpu_req = 1'b0;
        cpu_cmd = '0;
        build_table();
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        // idle outputs out of reset
        check("cpu_ack after reset", {31'b0, cpu_ack}, 32'd0);
        check("mem_req after reset", {31'b0, mem_req}, 32'd0);
        foreach (ops[i]) begin
            apply_op(ops[i], i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- sources.f
hw/dcache_pkg.sv
hw/dual_port_ram.sv
hw/dcache_tag_valid.sv
hw/dcache_data_array.sv
hw/dcache_replace.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the cache testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module dcache_tb -f sources.f -o vdcache_tb

# the run result is decided by the printed summary line
out=$(./obj_dir/vdcache_tb) || true
echo "$out"
if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
